// File: logic/wb_bus_defines.svh
`ifndef WB_BUS_DEFINES_SVH
`define WB_BUS_DEFINES_SVH

////////////////////
// bus sizing
////////////////////

// masters sharing the bus
`define WB_NUM_MASTERS 4

// word address and data widths
`define WB_ADDR_W 10
`define WB_DATA_W 32
`define WB_SEL_W (`WB_DATA_W / 8)

// words backed by the ram, anything above is unmapped
`define WB_RAM_DEPTH 256

// access cycles without ack before the bus answers with err
`define WB_WDOG_LIMIT 16

`endif

// File: logic/wb_bus_pkg.sv
`include "wb_bus_defines.svh"

package wb_bus_pkg;

  ////////////////////
  // scalar types
  ////////////////////

  // word address, data word and byte lanes
  typedef logic [`WB_ADDR_W-1:0] wb_addr_t;
  typedef logic [`WB_DATA_W-1:0] wb_data_t;
  typedef logic [`WB_SEL_W-1:0]  wb_sel_t;

  // master number as reported by the arbiter
  typedef logic [$clog2(`WB_NUM_MASTERS)-1:0] master_idx_t;

  // must be able to hold the limit itself
  typedef logic [$clog2(`WB_WDOG_LIMIT+1)-1:0] wdog_cnt_t;

  ////////////////////
  // bus structs
  ////////////////////

  // driven by a master, held until ack or err
  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_sel_t  sel;
    wb_data_t dat;
  } wb_req_t;

  // seen by a master, dat only meaningful with ack
  typedef struct packed {
    logic     ack;
    logic     err;
    wb_data_t dat;
  } wb_rsp_t;

  // one bus tenure
  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    RECOVER
  } tenure_state_e;

endpackage

// File: logic/rr_arb_tree.sv
`timescale 1ns/1ps
`include "wb_bus_defines.svh"

module rr_arb_tree import wb_bus_pkg::*; #(
  parameter int unsigned num_in = `WB_NUM_MASTERS
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // one request bit and one payload per input
  input  logic    [num_in-1:0] req_i,
  input  wb_req_t [num_in-1:0] data_i,
  output logic    [num_in-1:0] gnt_o,
  // arbitrated side, gnt_i terminates the current winner
  input  logic                 gnt_i,
  output logic                 req_o,
  output wb_req_t              data_o,
  output master_idx_t          idx_o
);

  // tree of two-input nodes, node 0 is the root
  localparam int unsigned num_levels = $clog2(num_in);
  localparam int unsigned num_nodes  = 2**num_levels - 1;

  logic    [num_nodes-1:0][num_levels-1:0] idx_nodes;
  wb_req_t [num_nodes-1:0]                 data_nodes;
  logic    [num_nodes-1:0]                 req_nodes;
  logic    [num_nodes-1:0]                 gnt_nodes;

  // rotating priority pointer
  logic [num_levels-1:0] rr_d, rr_q;
  // lock-in of the request vector
  logic [num_in-1:0] req_d, req_q;
  logic              lock_d, lock_q;

  // decision comes out of the root
  assign req_o  = req_nodes[0];
  assign data_o = data_nodes[0];
  assign idx_o  = master_idx_t'(idx_nodes[0]);

  ////////////////////
  // lock and pointer
  ////////////////////

  // a pending request without termination freezes the inputs seen by the tree
  assign lock_d = req_o & ~gnt_i;
  assign req_d  = lock_q ? req_q : req_i;

  // on termination move one step past the winner, wrap at the last input
  always_comb begin
    rr_d = rr_q;
    if (gnt_i && req_o) begin
      if (idx_nodes[0] == num_levels'(num_in - 1)) begin
        rr_d = '0;
      end else begin
        rr_d = idx_nodes[0] + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q   <= '0;
      req_q  <= '0;
      lock_q <= 1'b0;
    end else begin
      rr_q   <= rr_d;
      req_q  <= req_d;
      lock_q <= lock_d;
    end
  end

  ////////////////////
  // arbitration tree
  ////////////////////

  // grant enters at the root and walks down the selected path
  assign gnt_nodes[0] = gnt_i;

  for (genvar lvl = 0; lvl < num_levels; lvl++) begin : gen_level
    for (genvar n = 0; n < 2**lvl; n++) begin : gen_node
      localparam int unsigned node  = 2**lvl - 1 + n;
      localparam int unsigned child = 2**(lvl+1) - 1 + 2*n;

      if (lvl == num_levels - 1) begin : gen_leaf
        // leaves look straight at the request inputs
        if (2*n + 1 < num_in) begin : gen_pair
          logic sel;
          // right side wins if it asks and this level's pointer bit is set
          assign sel = ~req_d[2*n] | (req_d[2*n+1] & rr_q[num_levels-1-lvl]);
          assign req_nodes[node]  = req_d[2*n] | req_d[2*n+1];
          assign idx_nodes[node]  = num_levels'(sel);
          assign data_nodes[node] = sel ? data_i[2*n+1] : data_i[2*n];
          assign gnt_o[2*n]       = gnt_nodes[node] & req_d[2*n] & ~sel;
          assign gnt_o[2*n+1]     = gnt_nodes[node] & req_d[2*n+1] & sel;
        end else if (2*n + 1 == num_in) begin : gen_single
          // odd input count, last leaf has one input
          assign req_nodes[node]  = req_d[2*n];
          assign idx_nodes[node]  = '0;
          assign data_nodes[node] = data_i[2*n];
          assign gnt_o[2*n]       = gnt_nodes[node] & req_d[2*n];
        end else begin : gen_empty
          // padding leaf, never requests
          assign req_nodes[node]  = 1'b0;
          assign idx_nodes[node]  = '0;
          assign data_nodes[node] = '0;
        end
      end else begin : gen_inner
        logic sel;
        assign sel = ~req_nodes[child] | (req_nodes[child+1] & rr_q[num_levels-1-lvl]);
        assign req_nodes[node] = req_nodes[child] | req_nodes[child+1];
        // prepend this level's decision to the winning child's index
        assign idx_nodes[node] = sel ?
            num_levels'({1'b1, idx_nodes[child+1][num_levels-lvl-2:0]}) :
            num_levels'({1'b0, idx_nodes[child][num_levels-lvl-2:0]});
        assign data_nodes[node]   = sel ? data_nodes[child+1] : data_nodes[child];
        assign gnt_nodes[child]   = gnt_nodes[node] & ~sel;
        assign gnt_nodes[child+1] = gnt_nodes[node] & sel;
      end
    end
  end

endmodule

// File: logic/bus_tenure_fsm.sv
`timescale 1ns/1ps
`include "wb_bus_defines.svh"

module bus_tenure_fsm import wb_bus_pkg::*; (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // arbitrated request and owner from the tree
  input  logic                                arb_req_i,
  input  wb_req_t                             arb_data_i,
  input  logic    [`WB_NUM_MASTERS-1:0]       arb_gnt_i,
  output logic                                arb_gnt_o,
  // watchdog
  output logic                                wdog_run_o,
  input  logic                                wdog_expired_i,
  // ram port
  output wb_req_t                             ram_req_o,
  input  wb_rsp_t                             ram_rsp_i,
  // per master responses
  output wb_rsp_t [`WB_NUM_MASTERS-1:0]       m_rsp_o
);

  tenure_state_e state_d, state_q;
  logic          in_access;
  logic          done;

  assign in_access = (state_q == ACCESS);

  // tenure ends on ram ack or on watchdog expiry
  assign done = in_access & (ram_rsp_i.ack | wdog_expired_i);

  ////////////////////
  // state machine
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        // tree already holds a winner, start the access
        if (arb_req_i) begin
          state_d = ACCESS;
        end
      end
      ACCESS: begin
        if (done) begin
          state_d = RECOVER;
        end
      end
      RECOVER: begin
        // one cycle for the owner to drop cyc and stb
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////
  // outputs
  ////////////////////

  // termination also rotates the tree pointer and releases the lock
  assign arb_gnt_o  = done;
  assign wdog_run_o = in_access;

  // ram sees the owner's cycle only while in ACCESS
  always_comb begin
    ram_req_o     = arb_data_i;
    ram_req_o.cyc = arb_data_i.cyc & in_access;
    ram_req_o.stb = arb_data_i.stb & in_access;
  end

  // tree grant is one-hot on termination, so only the owner sees ack or err
  // err only when the watchdog fired, read data goes to everyone
  always_comb begin
    for (int m = 0; m < `WB_NUM_MASTERS; m++) begin
      m_rsp_o[m].ack = arb_gnt_i[m] & ram_rsp_i.ack & ~wdog_expired_i;
      m_rsp_o[m].err = arb_gnt_i[m] & wdog_expired_i;
      m_rsp_o[m].dat = ram_rsp_i.dat;
    end
  end

endmodule

// File: logic/tenure_watchdog.sv
`timescale 1ns/1ps
`include "wb_bus_defines.svh"

module tenure_watchdog import wb_bus_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  // high for every ACCESS cycle of a tenure
  input  logic run_i,
  // tenure has gone unanswered for the limit
  output logic expired_o
);

  ////////////////////
  // access counter
  ////////////////////

  localparam wdog_cnt_t limit = wdog_cnt_t'(`WB_WDOG_LIMIT);

  wdog_cnt_t cnt_q;

  // first ACCESS cycle sees zero, so expiry lands in the cycle after
  // limit full access cycles without ack
  // gated by run so the held count does not leak into RECOVER
  assign expired_o = run_i & (cnt_q == limit);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (!run_i) begin
      // every tenure starts from zero
      cnt_q <= '0;
    end else if (!expired_o) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

endmodule

// File: logic/wb_shared_ram.sv
`timescale 1ns/1ps

module wb_shared_ram import wb_bus_pkg::*; #(
  // mapped words, addresses at or above are never acked
  parameter int unsigned depth = 256
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  wb_req_t wb_req_i,
  output wb_rsp_t wb_rsp_o
);

  localparam int unsigned row_w   = $clog2(depth);
  localparam int unsigned lanes   = $bits(wb_sel_t);

  wb_data_t         mem_q [depth];
  wb_data_t         rdata_q;
  logic             ack_q;
  logic             mapped;
  logic             access;
  logic [row_w-1:0] row;

  assign row    = wb_req_i.adr[row_w-1:0];
  assign mapped = (wb_req_i.adr < depth);

  // classic handshake, one ack per strobe, ack_q blocks a second one
  assign access = wb_req_i.cyc & wb_req_i.stb & mapped & ~ack_q;

  ////////////////////
  // ack
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  ////////////////////
  // storage
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (access) begin
      if (wb_req_i.we) begin
        // byte lanes
        for (int b = 0; b < lanes; b++) begin
          if (wb_req_i.sel[b]) begin
            mem_q[row][8*b +: 8] <= wb_req_i.dat[8*b +: 8];
          end
        end
      end
      // loaded together with ack, a write returns the old word
      rdata_q <= mem_q[row];
    end
  end

  assign wb_rsp_o.ack = ack_q;
  // no slave error, unmapped cycles are left to the watchdog
  assign wb_rsp_o.err = 1'b0;
  assign wb_rsp_o.dat = rdata_q;

endmodule

// File: logic/wb_shared_bus.sv
`timescale 1ns/1ps
`include "wb_bus_defines.svh"

module wb_shared_bus import wb_bus_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  wb_req_t [`WB_NUM_MASTERS-1:0] wb_m_req_i,
  output wb_rsp_t [`WB_NUM_MASTERS-1:0] wb_m_rsp_o
);

  logic    [`WB_NUM_MASTERS-1:0] m_req;
  logic    [`WB_NUM_MASTERS-1:0] arb_gnt;
  logic                          arb_req;
  wb_req_t                       arb_data;
  // owner index, observed by the bound checks
  master_idx_t                   arb_idx;
  logic                          term_gnt;
  logic                          wdog_run;
  logic                          wdog_expired;
  wb_req_t                       ram_req;
  wb_rsp_t                       ram_rsp;

  // a master requests with cyc and stb together
  for (genvar m = 0; m < `WB_NUM_MASTERS; m++) begin : gen_req
    assign m_req[m] = wb_m_req_i[m].cyc & wb_m_req_i[m].stb;
  end

  ////////////////////
  // arbitration
  ////////////////////

  rr_arb_tree #(
    .num_in (`WB_NUM_MASTERS)
  ) arb_tree_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (m_req),
    .data_i (wb_m_req_i),
    .gnt_o  (arb_gnt),
    .gnt_i  (term_gnt),
    .req_o  (arb_req),
    .data_o (arb_data),
    .idx_o  (arb_idx)
  );

  ////////////////////
  // tenure control
  ////////////////////

  bus_tenure_fsm tenure_fsm_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .arb_req_i      (arb_req),
    .arb_data_i     (arb_data),
    .arb_gnt_i      (arb_gnt),
    .arb_gnt_o      (term_gnt),
    .wdog_run_o     (wdog_run),
    .wdog_expired_i (wdog_expired),
    .ram_req_o      (ram_req),
    .ram_rsp_i      (ram_rsp),
    .m_rsp_o        (wb_m_rsp_o)
  );

  tenure_watchdog watchdog_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .run_i     (wdog_run),
    .expired_o (wdog_expired)
  );

  // single slave
  wb_shared_ram #(
    .depth (`WB_RAM_DEPTH)
  ) ram_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wb_req_i (ram_req),
    .wb_rsp_o (ram_rsp)
  );

endmodule

// File: verification/wb_shared_bus_properties.sv
`timescale 1ns/1ps
`include "wb_bus_defines.svh"

module wb_shared_bus_properties import wb_bus_pkg::*; (
  input logic                          clk_i,
  input logic                          rst_ni,
  // master side of the bus
  input wb_req_t [`WB_NUM_MASTERS-1:0] m_req_i,
  input wb_rsp_t [`WB_NUM_MASTERS-1:0] m_rsp_i,
  // owner index and access phase from inside the top level
  input master_idx_t                   arb_idx_i,
  input logic                          wdog_run_i
);

  localparam int limit = `WB_WDOG_LIMIT;

  logic [`WB_NUM_MASTERS-1:0] acks;
  logic [`WB_NUM_MASTERS-1:0] errs;

  // number of failed assertions so far
  int unsigned fail_cnt = 0;

  ////////////////////
  // per master
  ////////////////////

  for (genvar m = 0; m < `WB_NUM_MASTERS; m++) begin : gen_master
    assign acks[m] = m_rsp_i[m].ack;
    assign errs[m] = m_rsp_i[m].err;

    // a termination only goes to a master that is running a cycle
    resp_needs_cyc: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (acks[m] | errs[m]) |-> m_req_i[m].cyc)
      else begin
        $error("master %0d got ack or err without cyc", m);
        fail_cnt++;
      end
  end

  ////////////////////
  // whole bus
  ////////////////////

  // one termination at most, over ack and err of every master
  one_term: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0({acks, errs}))
    else begin
      $error("several terminations in one cycle, ack %b err %b", acks, errs);
      fail_cnt++;
    end

  // lock-in keeps the owner for every cycle of ACCESS
  owner_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      wdog_run_i && $past(wdog_run_i) |-> $stable(arb_idx_i))
    else begin
      $error("owner index changed in the middle of a tenure");
      fail_cnt++;
    end

  // err only after exactly limit access cycles with no ack
  err_after_limit: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (|errs) |-> $past(wdog_run_i, limit) && !$past(wdog_run_i, limit + 1))
    else begin
      $error("err raised after a tenure of the wrong length");
      fail_cnt++;
    end

endmodule

bind wb_shared_bus wb_shared_bus_properties props_i (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .m_req_i    (wb_m_req_i),
  .m_rsp_i    (wb_m_rsp_o),
  .arb_idx_i  (arb_idx),
  .wdog_run_i (wdog_run)
);

// File: verification/wb_shared_bus_tb.sv
`timescale 1ns/1ps
`include "wb_bus_defines.svh"

module wb_shared_bus_tb import wb_bus_pkg::*; ();

  localparam int num_m          = `WB_NUM_MASTERS;
  // 200 transfers of at most 20 cycles plus half again
  localparam int max_xfers      = 200;
  localparam int xfer_cycles    = 20;
  localparam int timeout_cycles = max_xfers * xfer_cycles * 3 / 2;
  // random traffic stays in a small window so reads hit written words
  localparam int window         = 32;

  logic                clk_i;
  logic                rst_ni;
  wb_req_t [num_m-1:0] m_req;
  wb_rsp_t [num_m-1:0] m_rsp;

  // scoreboard copy of the ram and the byte lanes written so far
  wb_data_t model_mem   [`WB_RAM_DEPTH];
  wb_sel_t  model_known [`WB_RAM_DEPTH];

  master_idx_t served_q [$];
  master_idx_t last_winner;
  int unsigned checks;
  int unsigned errors;
  int unsigned xfers;
  int unsigned cycles;
  int unsigned err_mark;

  wb_shared_bus dut_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wb_m_req_i (m_req),
    .wb_m_rsp_o (m_rsp)
  );

  // 8 ns period
  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("timeout: transfers still pending after %0d cycles", timeout_cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  ////////////////////
  // helpers
  ////////////////////

  // own errors plus failed bound assertions
  function automatic int unsigned error_total();
    return errors + dut_i.props_i.fail_cnt;
  endfunction

  function automatic wb_data_t lane_mask(input wb_sel_t sel);
    wb_data_t mask;
    mask = '0;
    for (int b = 0; b < `WB_SEL_W; b++) begin
      if (sel[b]) begin
        mask[8*b +: 8] = 8'hff;
      end
    end
    return mask;
  endfunction

  task automatic compare_value(input string sig, input logic [31:0] exp,
                               input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s expected 'h%0h, got 'h%0h", $time, sig, exp, act);
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic finish_test(input int num, input string name);
    $display("test %0d %s: %0d errors", num, name, error_total() - err_mark);
    err_mark = error_total();
  endtask

  ////////////////////
  // master side
  ////////////////////

  // one classic cycle
  // lat counts falling edges until ack or err
  task automatic bus_transfer(input int m, input int wait_n, input logic we,
                              input wb_addr_t adr, input wb_sel_t sel, input wb_data_t dat,
                              output wb_data_t rdat, output logic got_err, output int lat);
    repeat (wait_n) @(negedge clk_i);
    m_req[m] = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, sel: sel, dat: dat};
    lat = 0;
    do begin
      @(negedge clk_i);
      lat++;
    end while (!m_rsp[m].ack && !m_rsp[m].err);
    rdat    = m_rsp[m].dat;
    got_err = m_rsp[m].err;
    served_q.push_back(master_idx_t'(m));
    xfers++;
    // write lands in the model when it is acked
    if (we && m_rsp[m].ack) begin
      for (int b = 0; b < `WB_SEL_W; b++) begin
        if (sel[b]) begin
          model_mem[adr][8*b +: 8] = dat[8*b +: 8];
        end
      end
      model_known[adr] = model_known[adr] | sel;
    end
    // hold through termination and drop in RECOVER
    @(negedge clk_i);
    m_req[m] = '0;
  endtask

  task automatic write_word(input int m, input int wait_n, input wb_addr_t adr,
                            input wb_sel_t sel, input wb_data_t dat);
    wb_data_t rdat;
    logic     got_err;
    int       lat;
    bus_transfer(m, wait_n, 1'b1, adr, sel, dat, rdat, got_err, lat);
    if (got_err) begin
      report_failure($sformatf("master %0d write to %h ended in err, not ack", m, adr));
    end
  endtask

  task automatic read_check(input int m, input int wait_n, input wb_addr_t adr);
    wb_data_t rdat;
    wb_data_t mask;
    logic     got_err;
    int       lat;
    bus_transfer(m, wait_n, 1'b0, adr, '1, '0, rdat, got_err, lat);
    // only lanes that were ever written are known
    mask = lane_mask(model_known[adr]);
    if (got_err) begin
      report_failure($sformatf("master %0d read of %h ended in err, not ack", m, adr));
    end else begin
      compare_value($sformatf("wb_m_rsp_o[%0d].dat", m), model_mem[adr] & mask, rdat & mask);
    end
  endtask

  task automatic random_write(input int m, input int wait_n);
    write_word(m, wait_n, wb_addr_t'($urandom_range(0, window - 1)), '1, $urandom());
  endtask

  task automatic random_traffic(input int m, input int n);
    wb_addr_t adr;
    wb_sel_t  sel;
    for (int i = 0; i < n; i++) begin
      adr = wb_addr_t'($urandom_range(0, window - 1));
      if ($urandom_range(0, 1) == 0) begin
        // mostly full words and now and then a lane mix
        sel = ($urandom_range(0, 3) == 0) ? wb_sel_t'($urandom()) : '1;
        write_word(m, 1 + $urandom_range(0, 2), adr, sel, $urandom());
      end else begin
        read_check(m, 1 + $urandom_range(0, 2), adr);
      end
    end
  endtask

  ////////////////////
  // test sequence
  ////////////////////

  initial begin
    wb_data_t word;
    wb_addr_t adr;
    wb_addr_t adr2;
    wb_data_t rdat;
    logic     got_err;
    int       lat;
    int       per_master;
    void'($urandom(32'h9ed8));
    clk_i    = 1'b0;
    rst_ni   = 1'b0;
    m_req    = '0;
    checks   = 0;
    errors   = 0;
    xfers    = 0;
    cycles   = 0;
    err_mark = 0;
    for (int i = 0; i < `WB_RAM_DEPTH; i++) begin
      model_known[i] = '0;
    end
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // write then read back
    // ack two edges after the request is sampled
    adr  = wb_addr_t'($urandom_range(0, `WB_RAM_DEPTH - 1));
    word = $urandom();
    write_word(1, 1, adr, '1, word);
    bus_transfer(1, 1, 1'b0, adr, '1, '0, rdat, got_err, lat);
    compare_value("wb_m_rsp_o[1].dat", word, rdat);
    compare_value("ack latency", 2, lat);
    finish_test(1, "write then read");

    // partial writes over a full word
    adr2 = wb_addr_t'($urandom_range(0, `WB_RAM_DEPTH - 1));
    write_word(1, 1, adr2, '1, $urandom());
    write_word(1, 1, adr2, 4'b0101, $urandom());
    read_check(1, 1, adr2);
    write_word(1, 1, adr2, 4'b1000, $urandom());
    read_check(1, 1, adr2);
    finish_test(2, "byte selects");

    // full rounds each started after a single transfer that moves the pointer
    for (int r = 0; r < num_m; r++) begin
      random_write(r, 1);
      last_winner = master_idx_t'(r);
      served_q.delete();
      fork
        random_write(0, 1);
        random_write(1, 1);
        random_write(2, 1);
        random_write(3, 1);
      join
      for (int k = 0; k < num_m; k++) begin
        compare_value($sformatf("served order slot %0d", k),
                      (int'(last_winner) + 1 + k) % num_m, served_q[k]);
      end
    end
    finish_test(3, "round robin");

    // unmapped word gets err in the cycle opened by edge limit + 1
    // counting the edge that sampled the request
    adr = wb_addr_t'($urandom_range(`WB_RAM_DEPTH, 2**`WB_ADDR_W - 1));
    bus_transfer(3, 1, 1'b1, adr, '1, $urandom(), rdat, got_err, lat);
    compare_value("wb_m_rsp_o[3].err", 1, got_err);
    compare_value("err latency", `WB_WDOG_LIMIT + 1, lat);
    adr = wb_addr_t'($urandom_range(0, `WB_RAM_DEPTH - 1));
    write_word(3, 1, adr, '1, $urandom());
    read_check(3, 1, adr);
    finish_test(4, "unmapped address");

    // master 0 raises while master 2 owns the bus
    served_q.delete();
    fork
      read_check(2, 1, adr2);
      write_word(0, 2, wb_addr_t'($urandom_range(0, window - 1)), '1, $urandom());
    join
    compare_value("served order slot 0", 2, served_q[0]);
    compare_value("served order slot 1", 0, served_q[1]);
    finish_test(5, "request during tenure");

    // everyone at once for the rest of the budget
    per_master = (max_xfers - xfers) / num_m;
    for (int m = 0; m < num_m; m++) begin
      fork
        automatic int mm = m;
        random_traffic(mm, per_master);
      join_none
    end
    wait fork;
    repeat (4) @(negedge clk_i);
    finish_test(6, "random traffic");

    $display("6 tests, %0d transfers, %0d checks, %0d errors", xfers, checks, error_total());
    if (error_total() == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+logic
logic/wb_bus_pkg.sv
logic/rr_arb_tree.sv
logic/bus_tenure_fsm.sv
logic/tenure_watchdog.sv
logic/wb_shared_ram.sv
logic/wb_shared_bus.sv
verification/wb_shared_bus_properties.sv
verification/wb_shared_bus_tb.sv
